// ==== design/sid_filter_pkg.sv ====
`default_nettype none

package sid_filter_pkg;

    localparam int SAMPLE_W     = 18;
    localparam int FC_W         = 11;
    localparam int NF_BIAS      = 16384;   // unfiltered sum start
    localparam int CUTOFF_SCALE = 82355;   // linear cutoff slope

    // reciprocal of resonance, 1024 is unity
    function automatic logic [10:0] res_coef(input logic [3:0] res);
        case (res)
            4'd0:    return 11'd1433;
            4'd1:    return 11'd1313;
            4'd2:    return 11'd1202;
            4'd3:    return 11'd1104;
            4'd4:    return 11'd1024;
            4'd5:    return 11'd938;
            4'd6:    return 11'd859;
            4'd7:    return 11'd788;
            4'd8:    return 11'd716;
            4'd9:    return 11'd656;
            4'd10:   return 11'd601;
            4'd11:   return 11'd552;
            4'd12:   return 11'd512;
            4'd13:   return 11'd469;
            4'd14:   return 11'd429;
            default: return 11'd394;
        endcase
    endfunction

    function automatic logic signed [SAMPLE_W-1:0] add_sat(
        input logic signed [SAMPLE_W-1:0] a,
        input logic signed [SAMPLE_W-1:0] b
    );
        logic [SAMPLE_W:0] sum;
        sum = {a[SAMPLE_W-1], a} + {b[SAMPLE_W-1], b};
        // top two bits disagree on overflow, clamp toward true sign
        if (sum[SAMPLE_W] != sum[SAMPLE_W-1])
            return {sum[SAMPLE_W], {(SAMPLE_W-1){sum[SAMPLE_W-1]}}};
        return sum[SAMPLE_W-1:0];
    endfunction

    function automatic logic signed [SAMPLE_W-1:0] sub_sat(
        input logic signed [SAMPLE_W-1:0] a,
        input logic signed [SAMPLE_W-1:0] b
    );
        logic [SAMPLE_W:0] diff;
        diff = {a[SAMPLE_W-1], a} - {b[SAMPLE_W-1], b};
        if (diff[SAMPLE_W] != diff[SAMPLE_W-1])
            return {diff[SAMPLE_W], {(SAMPLE_W-1){diff[SAMPLE_W-1]}}};
        return diff[SAMPLE_W-1:0];
    endfunction

endpackage

`default_nettype wire

// ==== design/sid_voice_router.sv ====
`timescale 1ns/100ps
`default_nettype none

module sid_voice_router (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 input_valid,
    input  wire signed [sid_filter_pkg::SAMPLE_W-1:0] voice1,
    input  wire signed [sid_filter_pkg::SAMPLE_W-1:0] voice2,
    input  wire signed [sid_filter_pkg::SAMPLE_W-1:0] voice3,
    input  wire signed [sid_filter_pkg::SAMPLE_W-1:0] ext_in,
    input  wire        [sid_filter_pkg::FC_W-1:0]     fc,
    input  wire        [7:0]                        res_filt,
    input  wire        [7:0]                        mode_vol,
    input  wire                                 enable,
    output logic signed [sid_filter_pkg::SAMPLE_W-1:0] vi,
    output logic signed [sid_filter_pkg::SAMPLE_W-1:0] vnf,
    output logic signed [sid_filter_pkg::SAMPLE_W-1:0] w0,
    output logic       [10:0]                       q,
    output logic       [2:0]                        mix_sel,
    output logic       [3:0]                        volume,
    output logic                                filt_on,
    output logic                                mix_valid
);

    localparam int SW = sid_filter_pkg::SAMPLE_W;

    logic [2:0]           step;      // 0 idle, 1..4 add, 5 publish
    logic                 accept;
    logic signed [SW-1:0] v1_r;
    logic signed [SW-1:0] v2_r;
    logic signed [SW-1:0] v3_r;
    logic signed [SW-1:0] ext_r;
    logic [3:0]           route_r;
    logic                 mute_r;
    logic signed [SW-1:0] acc_vi;
    logic signed [SW-1:0] acc_vnf;
    logic signed [SW-1:0] w0_p;
    logic [10:0]          q_p;
    logic [2:0]           sel_p;
    logic [3:0]           vol_p;
    logic                 on_p;
    logic [35:0]          fc_prod;
    logic signed [SW-1:0] cur;
    logic                 cur_to_filt;
    logic                 cur_skip;

    // publish cycle doubles as idle, so strobes 5 apart are taken
    assign accept  = input_valid && (step == 3'd0 || step == 3'd5);
    assign fc_prod = 36'(sid_filter_pkg::CUTOFF_SCALE) * (36'(fc) + 36'd1);

    always_comb begin
        case (step)
            3'd1: begin
                cur         = v1_r;
                cur_to_filt = route_r[0];
            end
            3'd2: begin
                cur         = v2_r;
                cur_to_filt = route_r[1];
            end
            3'd3: begin
                cur         = v3_r;
                cur_to_filt = route_r[2];
            end
            default: begin
                cur         = ext_r;
                cur_to_filt = route_r[3];
            end
        endcase
    end

    assign cur_skip = (step == 3'd3) && !route_r[2] && mute_r;   // voice3 mute

    always_ff @(posedge clk) begin
        if (rst) begin
            step      <= 3'd0;
            mix_valid <= 1'b0;
        end else begin
            mix_valid <= (step == 3'd5);
            if (accept)
                step <= 3'd1;
            else if (step == 3'd5)
                step <= 3'd0;
            else if (step != 3'd0)
                step <= step + 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            v1_r    <= voice1;
            v2_r    <= voice2;
            v3_r    <= voice3;
            ext_r   <= ext_in;
            route_r <= res_filt[3:0];
            mute_r  <= mode_vol[7];
            acc_vi  <= '0;
            acc_vnf <= SW'(sid_filter_pkg::NF_BIAS);
            w0_p    <= {fc_prod[35], fc_prod[28:12]};
            q_p     <= sid_filter_pkg::res_coef(res_filt[7:4]);
            sel_p   <= mode_vol[6:4];
            vol_p   <= mode_vol[3:0];
            on_p    <= enable;
        end else if (step >= 3'd1 && step <= 3'd4) begin
            if (cur_to_filt)
                acc_vi <= sid_filter_pkg::add_sat(acc_vi, cur);
            else if (!cur_skip)
                acc_vnf <= sid_filter_pkg::add_sat(acc_vnf, cur);
        end
        if (step == 3'd5) begin   // outputs hold until the next publish
            vi      <= acc_vi;
            vnf     <= acc_vnf;
            w0      <= w0_p;
            q       <= q_p;
            mix_sel <= sel_p;
            volume  <= vol_p;
            filt_on <= on_p;
        end
    end

endmodule

`default_nettype wire

// ==== design/sid_svf_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module sid_svf_core (
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire                                  mix_valid,
    input  wire signed [sid_filter_pkg::SAMPLE_W-1:0]  vi,
    input  wire signed [sid_filter_pkg::SAMPLE_W-1:0]  w0,
    input  wire        [10:0]                        q,
    output logic signed [sid_filter_pkg::SAMPLE_W-1:0] vbp,
    output logic signed [sid_filter_pkg::SAMPLE_W-1:0] vlp,
    output logic signed [sid_filter_pkg::SAMPLE_W-1:0] vhp,
    output logic signed [sid_filter_pkg::SAMPLE_W-1:0] vi_out,
    output logic                                 filt_valid
);

    localparam int SW = sid_filter_pkg::SAMPLE_W;

    logic [2:0]           step;   // steps completed, 0 when idle
    logic                 start;
    logic signed [SW-1:0] w0_r;
    logic [10:0]          q_r;
    logic signed [SW-1:0] vi_r;
    logic signed [SW-1:0] dbp;
    logic signed [SW-1:0] mul_a;
    logic signed [SW-1:0] mul_b;
    logic signed [35:0]   prod;
    logic signed [SW-1:0] dv;     // w0 product scaled back
    logic signed [SW-1:0] qv;     // q product, 1024 is unity

    assign start = mix_valid && (step == 3'd0);

    // one shared multiplier across steps 1, 3 and 4
    always_comb begin
        case (step)
            3'd2: begin
                mul_a = w0_r;
                mul_b = vbp;
            end
            3'd3: begin
                mul_a = $signed({7'd0, q_r});
                mul_b = vbp;
            end
            default: begin
                mul_a = w0;   // step 1 reads the router directly
                mul_b = vhp;
            end
        endcase
    end

    assign prod = mul_a * mul_b;
    assign dv   = {prod[35], prod[35:19]};
    assign qv   = {prod[35], prod[26:10]};

    always_ff @(posedge clk) begin
        if (rst) begin
            step       <= 3'd0;
            filt_valid <= 1'b0;
            vbp        <= '0;
            vlp        <= '0;
            vhp        <= '0;
        end else begin
            filt_valid <= 1'b0;
            case (step)
                3'd0: begin
                    if (start)
                        step <= 3'd1;
                end
                3'd1: begin
                    vbp  <= sid_filter_pkg::sub_sat(vbp, dbp);
                    step <= 3'd2;
                end
                3'd2: begin
                    vlp  <= sid_filter_pkg::sub_sat(vlp, dv);   // uses new vbp
                    step <= 3'd3;
                end
                3'd3: begin
                    vhp  <= sid_filter_pkg::sub_sat(qv, vlp);
                    step <= 3'd4;
                end
                3'd4: begin
                    vhp        <= sid_filter_pkg::sub_sat(vhp, vi_r);
                    filt_valid <= 1'b1;
                    step       <= 3'd0;
                end
                default: step <= 3'd0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            dbp  <= dv;
            w0_r <= w0;
            q_r  <= q;
            vi_r <= vi;
        end
        if (step == 3'd4)
            vi_out <= vi_r;   // bypass value for the mixer
    end

endmodule

`default_nettype wire

// ==== design/sid_output_mixer.sv ====
`timescale 1ns/100ps
`default_nettype none

module sid_output_mixer (
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire                                  filt_valid,
    input  wire signed [sid_filter_pkg::SAMPLE_W-1:0]  vbp,
    input  wire signed [sid_filter_pkg::SAMPLE_W-1:0]  vlp,
    input  wire signed [sid_filter_pkg::SAMPLE_W-1:0]  vhp,
    input  wire signed [sid_filter_pkg::SAMPLE_W-1:0]  vi,
    input  wire signed [sid_filter_pkg::SAMPLE_W-1:0]  vnf,
    input  wire        [2:0]                         mix_sel,
    input  wire        [3:0]                         volume,
    input  wire                                  filt_on,
    output logic signed [sid_filter_pkg::SAMPLE_W-1:0] sound
);

    localparam int SW = sid_filter_pkg::SAMPLE_W;

    logic signed [SW-1:0] vnf_d;
    logic [2:0]           sel_d;
    logic [3:0]           vol_d;
    logic                 on_d;
    logic signed [SW-1:0] s_bp;
    logic signed [SW-1:0] s_lp;
    logic signed [SW-1:0] s_hp;
    logic signed [SW-1:0] fsum;
    logic signed [SW-1:0] vnf_s;
    logic signed [SW-1:0] vi_s;
    logic                 on_s;
    logic [3:0]           vol_s;
    logic signed [SW-1:0] mix;
    logic [3:0]           vol_m;
    logic                 stage2_valid;
    logic                 stage3_valid;
    logic signed [22:0]   prod;

    // router may publish the next sample on the filt_valid edge
    always_ff @(posedge clk) begin
        vnf_d <= vnf;
        sel_d <= mix_sel;
        vol_d <= volume;
        on_d  <= filt_on;
    end

    // bit 1 band-pass, bit 0 low-pass, bit 2 high-pass
    assign s_bp = sel_d[1] ? sid_filter_pkg::add_sat('0, vbp) : '0;
    assign s_lp = sel_d[0] ? sid_filter_pkg::add_sat(s_bp, vlp) : s_bp;
    assign s_hp = sel_d[2] ? sid_filter_pkg::add_sat(s_lp, vhp) : s_lp;

    assign prod = mix * $signed({1'b0, vol_m});

    always_ff @(posedge clk) begin
        if (filt_valid) begin
            fsum  <= s_hp;
            vnf_s <= vnf_d;
            vi_s  <= vi;
            on_s  <= on_d;
            vol_s <= vol_d;
        end
        if (stage2_valid) begin
            mix   <= sid_filter_pkg::add_sat(vnf_s, on_s ? fsum : vi_s);   // bypass when off
            vol_m <= vol_s;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage2_valid <= 1'b0;
            stage3_valid <= 1'b0;
            sound        <= '0;
        end else begin
            stage2_valid <= filt_valid;
            stage3_valid <= stage2_valid;
            if (stage3_valid) begin
                if (prod[21] != prod[20])
                    sound <= {prod[21], {(SW-1){prod[20]}}};   // clip
                else
                    sound <= prod[20:3];
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/sid_filter_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module sid_filter_top (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire signed [sid_filter_pkg::SAMPLE_W-1:0] voice1,
    input  wire signed [sid_filter_pkg::SAMPLE_W-1:0] voice2,
    input  wire signed [sid_filter_pkg::SAMPLE_W-1:0] voice3,
    input  wire signed [sid_filter_pkg::SAMPLE_W-1:0] ext_in,
    input  wire        [sid_filter_pkg::FC_W-1:0]     fc,
    input  wire        [7:0]                        res_filt,
    input  wire        [7:0]                        mode_vol,
    input  wire                                 enable,
    input  wire                                 input_valid,
    output wire signed [sid_filter_pkg::SAMPLE_W-1:0] sound
);

    localparam int SW = sid_filter_pkg::SAMPLE_W;

    wire signed [SW-1:0] vi;
    wire signed [SW-1:0] vnf;
    wire signed [SW-1:0] w0;
    wire        [10:0]   q;
    wire        [2:0]    mix_sel;
    wire        [3:0]    volume;
    wire                 filt_on;
    wire                 mix_valid;
    wire signed [SW-1:0] vbp;
    wire signed [SW-1:0] vlp;
    wire signed [SW-1:0] vhp;
    wire signed [SW-1:0] core_vi;   // registered copy for bypass
    wire                 filt_valid;

    sid_voice_router u_router (
        .clk         (clk),
        .rst         (rst),
        .input_valid (input_valid),
        .voice1      (voice1),
        .voice2      (voice2),
        .voice3      (voice3),
        .ext_in      (ext_in),
        .fc          (fc),
        .res_filt    (res_filt),
        .mode_vol    (mode_vol),
        .enable      (enable),
        .vi          (vi),
        .vnf         (vnf),
        .w0          (w0),
        .q           (q),
        .mix_sel     (mix_sel),
        .volume      (volume),
        .filt_on     (filt_on),
        .mix_valid   (mix_valid)
    );

    sid_svf_core u_core (
        .clk        (clk),
        .rst        (rst),
        .mix_valid  (mix_valid),
        .vi         (vi),
        .w0         (w0),
        .q          (q),
        .vbp        (vbp),
        .vlp        (vlp),
        .vhp        (vhp),
        .vi_out     (core_vi),
        .filt_valid (filt_valid)
    );

    sid_output_mixer u_mixer (
        .clk        (clk),
        .rst        (rst),
        .filt_valid (filt_valid),
        .vbp        (vbp),
        .vlp        (vlp),
        .vhp        (vhp),
        .vi         (core_vi),
        .vnf        (vnf),
        .mix_sel    (mix_sel),
        .volume     (volume),
        .filt_on    (filt_on),
        .sound      (sound)
    );

endmodule

`default_nettype wire

// ==== sim/sid_filter_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

module sid_filter_asserts (
    input wire                                 clk,
    input wire                                 rst,
    input wire                                 input_valid,
    input wire                                 mix_valid,
    input wire                                 filt_valid,
    input wire signed [sid_filter_pkg::SAMPLE_W-1:0] sound
);

    logic [2:0] busy_cnt;   // router add edges still to come
    logic       taken;

    assign taken = input_valid && (busy_cnt == 3'd0);

    always_ff @(posedge clk) begin
        if (rst)
            busy_cnt <= 3'd0;
        else if (taken)
            busy_cnt <= 3'd4;
        else if (busy_cnt != 3'd0)
            busy_cnt <= busy_cnt - 3'd1;
    end

    mix_to_filt: assert property (@(posedge clk) disable iff (rst)
        $past(mix_valid, 5) |-> filt_valid)
        else $error("filt_valid missing 5 edges after mix_valid");

    filt_from_mix: assert property (@(posedge clk) disable iff (rst)
        filt_valid |-> $past(mix_valid, 5))
        else $error("filt_valid without mix_valid 5 edges before");

    sound_timing: assert property (@(posedge clk) disable iff (rst)
        !$stable(sound) |-> $past(taken, 14))
        else $error("sound changed outside its slot after an accepted strobe");

    strobe_when_idle: assert property (@(posedge clk) disable iff (rst)
        input_valid |-> busy_cnt == 3'd0)
        else $error("input_valid raised while the router was busy");

endmodule

bind sid_filter_top sid_filter_asserts asserts_i (
    .clk         (clk),
    .rst         (rst),
    .input_valid (input_valid),
    .mix_valid   (mix_valid),
    .filt_valid  (filt_valid),
    .sound       (sound)
);

`default_nettype wire

// ==== sim/tb_sid_filter.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_sid_filter;

    localparam int SW         = sid_filter_pkg::SAMPLE_W;
    localparam int CLK_PERIOD = 20;
    localparam int LATENCY    = 13;   // accept edge to new sound
    localparam int MAX_GAP    = 9;
    localparam int N_BASIC    = 12;
    localparam int N_RANDOM   = 400;
    localparam int N_MUTE     = 40;
    localparam int N_BYPASS   = 40;
    localparam int N_SAT      = 40;
    localparam int N_BURST    = 60;
    localparam int N_TOTAL    = N_BASIC + N_RANDOM + N_MUTE + N_BYPASS + N_SAT + N_BURST;
    localparam int LIMIT_NS   = (N_TOTAL * MAX_GAP + 100) * CLK_PERIOD;
    localparam longint S_MAX  = 131071;
    localparam longint S_MIN  = -131072;
    localparam int RES_TABLE [16] = '{1433, 1313, 1202, 1104, 1024, 938, 859, 788,
                                     716, 656, 601, 552, 512, 469, 429, 394};

    logic                 clk;
    logic                 rst;
    logic signed [SW-1:0] voice1;
    logic signed [SW-1:0] voice2;
    logic signed [SW-1:0] voice3;
    logic signed [SW-1:0] ext_in;
    logic [10:0]          fc;
    logic [7:0]           res_filt;
    logic [7:0]           mode_vol;
    logic                 enable;
    logic                 input_valid;
    wire signed [SW-1:0]  sound;

    logic signed [SW-1:0] m_bp;   // model integrators
    logic signed [SW-1:0] m_lp;
    logic signed [SW-1:0] m_hp;
    int                   cycle = 0;
    logic [SW-1:0]        exp_q [$];
    int                   due_q [$];

    sid_filter_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .voice1      (voice1),
        .voice2      (voice2),
        .voice3      (voice3),
        .ext_in      (ext_in),
        .fc          (fc),
        .res_filt    (res_filt),
        .mode_vol    (mode_vol),
        .enable      (enable),
        .input_valid (input_valid),
        .sound       (sound)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic signed [SW-1:0] clamp_sample(input longint v);
        if (v > S_MAX)
            return SW'(S_MAX);
        if (v < S_MIN)
            return SW'(S_MIN);
        return SW'(v);
    endfunction

    function automatic logic signed [SW-1:0] sum_clip(input logic signed [SW-1:0] a,
                                                      input logic signed [SW-1:0] b);
        return clamp_sample(longint'(a) + longint'(b));
    endfunction

    function automatic logic signed [SW-1:0] diff_clip(input logic signed [SW-1:0] a,
                                                       input logic signed [SW-1:0] b);
        return clamp_sample(longint'(a) - longint'(b));
    endfunction

    function automatic logic signed [SW-1:0] rand_sample(input int shift);
        logic signed [SW-1:0] s;
        s = SW'($urandom());
        return s >>> shift;
    endfunction

    function automatic logic signed [SW-1:0] extreme_sample();
        case ($urandom_range(3))
            0:       return SW'(S_MAX);
            1:       return SW'(S_MIN);
            2:       return SW'(S_MAX - longint'($urandom_range(1000)));
            default: return SW'(S_MIN + longint'($urandom_range(1000)));
        endcase
    endfunction

    task automatic check_value(input string name, input logic [SW-1:0] actual,
                               input logic [SW-1:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s = %0d, expected %0d", $time, name,
                     $signed(actual), $signed(expected));
            $display("RESULT: FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    // reference model for one sample at strobe time
    task automatic predict_sound();
        logic signed [SW-1:0] s_vi;
        logic signed [SW-1:0] s_vnf;
        logic signed [SW-1:0] w0_m;
        logic signed [SW-1:0] qv;
        logic signed [SW-1:0] fsum;
        logic signed [SW-1:0] mix;
        logic [63:0]          fc_p;
        logic [63:0]          wide;
        int                   q_m;
        s_vi  = '0;
        s_vnf = SW'(sid_filter_pkg::NF_BIAS);
        if (res_filt[0]) s_vi = sum_clip(s_vi, voice1);
        else s_vnf = sum_clip(s_vnf, voice1);
        if (res_filt[1]) s_vi = sum_clip(s_vi, voice2);
        else s_vnf = sum_clip(s_vnf, voice2);
        if (res_filt[2]) s_vi = sum_clip(s_vi, voice3);
        else if (!mode_vol[7]) s_vnf = sum_clip(s_vnf, voice3);   // mute
        if (res_filt[3]) s_vi = sum_clip(s_vi, ext_in);
        else s_vnf = sum_clip(s_vnf, ext_in);

        fc_p = longint'(sid_filter_pkg::CUTOFF_SCALE) * (longint'(fc) + 1);
        w0_m = {fc_p[35], fc_p[28:12]};
        q_m  = RES_TABLE[res_filt[7:4]];

        m_bp = diff_clip(m_bp, SW'((longint'(w0_m) * longint'(m_hp)) >>> 19));
        m_lp = diff_clip(m_lp, SW'((longint'(w0_m) * longint'(m_bp)) >>> 19));
        wide = longint'(q_m) * longint'(m_bp);
        qv   = {wide[35], wide[26:10]};   // upper bits drop off
        m_hp = diff_clip(qv, m_lp);
        m_hp = diff_clip(m_hp, s_vi);

        fsum = '0;
        if (mode_vol[5]) fsum = sum_clip(fsum, m_bp);
        if (mode_vol[4]) fsum = sum_clip(fsum, m_lp);
        if (mode_vol[6]) fsum = sum_clip(fsum, m_hp);
        mix = sum_clip(s_vnf, enable ? fsum : s_vi);

        exp_q.push_back(clamp_sample((longint'(mix) * longint'(mode_vol[3:0])) >>> 3));
        due_q.push_back(cycle + LATENCY + 1);   // accepted on the next edge
    endtask

    task automatic randomize_inputs();
        voice1   = rand_sample(2);
        voice2   = rand_sample(2);
        voice3   = rand_sample(2);
        ext_in   = rand_sample(2);
        fc       = 11'($urandom());
        res_filt = 8'($urandom());
        mode_vol = 8'($urandom());
        enable   = 1'b1;
    endtask

    // entered and left 2 ns after a rising edge
    task automatic strobe(input int gap);
        input_valid = 1'b1;
        predict_sound();
        @(posedge clk);
        #2;
        input_valid = 1'b0;
        repeat (gap - 1) begin
            @(posedge clk);
            #2;
        end
    endtask

    always @(negedge clk) begin
        if (due_q.size() != 0 && due_q[0] == cycle) begin
            check_value("sound", sound, exp_q[0]);
            void'(due_q.pop_front());
            void'(exp_q.pop_front());
        end
    end

    initial begin
        #(LIMIT_NS);
        $display("timeout: sound results still missing after %0d ns", LIMIT_NS);
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(91));
        clk         = 1'b0;
        rst         = 1'b1;
        input_valid = 1'b0;
        voice1      = '0;
        voice2      = '0;
        voice3      = '0;
        ext_in      = '0;
        fc          = '0;
        res_filt    = '0;
        mode_vol    = '0;
        enable      = 1'b0;
        m_bp        = '0;
        m_lp        = '0;
        m_hp        = '0;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        check_value("sound", sound, '0);
        @(posedge clk);
        #2;

        for (int i = 0; i < N_BASIC; i++) begin   // unfiltered path only
            randomize_inputs();
            voice1        = voice1 >>> 2;
            voice2        = voice2 >>> 2;
            res_filt[3:0] = 4'b0000;
            mode_vol[7:4] = 4'b0000;
            strobe(5 + $urandom_range(4));
        end
        for (int i = 0; i < N_RANDOM; i++) begin
            randomize_inputs();
            strobe(5 + $urandom_range(4));
        end
        for (int i = 0; i < N_MUTE; i++) begin
            randomize_inputs();
            mode_vol[7] = 1'b1;
            strobe(5 + $urandom_range(4));
        end
        for (int i = 0; i < N_BYPASS; i++) begin
            randomize_inputs();
            enable = 1'b0;
            strobe(5 + $urandom_range(4));
        end
        for (int i = 0; i < N_SAT; i++) begin
            randomize_inputs();
            voice1        = extreme_sample();
            voice2        = extreme_sample();
            voice3        = extreme_sample();
            ext_in        = extreme_sample();
            mode_vol[3:0] = 4'hf;
            enable        = 1'($urandom());
            strobe(5 + $urandom_range(4));
        end
        for (int i = 0; i < N_BURST; i++) begin   // three samples in flight
            randomize_inputs();
            strobe(5);
        end

        while (due_q.size() != 0)
            @(posedge clk);
        repeat (20) @(posedge clk);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
design/sid_filter_pkg.sv
design/sid_voice_router.sv
design/sid_svf_core.sv
design/sid_output_mixer.sv
design/sid_filter_top.sv
sim/sid_filter_asserts.sv
sim/tb_sid_filter.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_sid_filter
FILELIST  = compile.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
